//--- include/gf_settings.svh
`ifndef GF_SETTINGS_SVH
`define GF_SETTINGS_SVH

// Field degree, GF(2^8)
`define GF_M 8

// x^8+x^4+x^3+x^2+1 without the x^8 term
`define GF_POLY 8'h1D

// Multiplicative identity in standard basis
`define GF_ONE 8'h01

// a^(2^M-2) needs M-1 square-and-multiply steps after the load
`define GF_INV_STEPS (`GF_M - 1)

// One step per exponent bit
`define GF_POW_STEPS `GF_M

`endif

//--- hdl/gf_pkg.sv
`include "gf_settings.svh"

package gf_pkg;

	typedef logic [`GF_M-1:0] gf_elem_t; // Standard basis element
	typedef logic [`GF_M-1:0] gf_exp_t;  // Exponent 0 .. 2^M-1

	typedef enum logic [2:0] {
		OP_MUL,
		OP_SQR,
		OP_CUBE,
		OP_INV,
		OP_POW
	} gf_op_t;

	// Second operand word, element for MUL or exponent for POW
	typedef union packed {
		gf_elem_t elem;
		gf_exp_t  exp;
	} gf_operand_u;

	typedef struct packed {
		gf_op_t      op;
		gf_elem_t    a;
		gf_operand_u b;
	} gf_cmd_t;

	typedef enum logic [2:0] {
		MODE_MUL,
		MODE_SQR,
		MODE_CUBE,
		MODE_INV_STEP,
		MODE_POW_STEP
	} gf_mode_t;

	typedef struct packed {
		logic     load;    // Capture a, seed acc
		gf_mode_t mode;
		logic     run;     // Apply one iteration
		logic     exp_bit; // Current exponent bit, MSB first
	} gf_step_t;

	typedef struct packed {
		gf_op_t   op;
		gf_elem_t value;
	} gf_result_t;

	// Multiply by alpha: shift up and fold x^M back through the polynomial
	function automatic gf_elem_t gf_mul_alpha(gf_elem_t x);
		return {x[`GF_M-2:0], 1'b0} ^ (x[`GF_M-1] ? gf_elem_t'(`GF_POLY) : gf_elem_t'(0));
	endfunction

	function automatic gf_elem_t gf_alpha_pow(int n);
		gf_elem_t e;
		e = `GF_ONE;
		for (int i = 0; i < n; i++)
			e = gf_mul_alpha(e);
		return e;
	endfunction

endpackage

//--- hdl/gf_mult.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

// Bit-parallel standard basis multiplier
module gf_mult (
	input  gf_pkg::gf_elem_t a,
	input  gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t p
);

	// blk[i] holds alpha^i * a
	gf_pkg::gf_elem_t blk [`GF_M];

	genvar i;

	generate
		for (i = 0; i < `GF_M; i++) begin : g_blk
			if (i == 0) begin : g_first
				assign blk[i] = a;
			end else begin : g_shift
				assign blk[i] = gf_pkg::gf_mul_alpha(blk[i-1]); // One more alpha per block
			end
		end
	endgenerate

	// Bit i of the product takes bit i of every block selected by b
	always_comb begin
		gf_pkg::gf_elem_t z;
		for (int n = 0; n < `GF_M; n++) begin
			for (int j = 0; j < `GF_M; j++)
				z[j] = blk[j][n];
			p[n] = ^(z & b);
		end
	end

endmodule

//--- hdl/gf_power_map.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

// Squarer and cuber as constant XOR matrices
module gf_power_map (
	input  gf_pkg::gf_elem_t x,
	output gf_pkg::gf_elem_t sq,
	output gf_pkg::gf_elem_t cube
);

	// Single terms x_i followed by all pairs x_i & x_j with i < j
	localparam int NT = `GF_M * (`GF_M + 1) / 2;

	function automatic int pair_idx(int i, int j);
		return `GF_M + i * `GF_M - (i * (i + 1)) / 2 + (j - i - 1);
	endfunction

	// Input bits that land in bit pos of x^2
	function automatic gf_pkg::gf_elem_t sq_mask(int pos);
		gf_pkg::gf_elem_t m;
		gf_pkg::gf_elem_t e;
		for (int j = 0; j < `GF_M; j++) begin
			e    = gf_pkg::gf_alpha_pow(2 * j);
			m[j] = e[pos];
		end
		return m;
	endfunction

	// x^3 = sum x_i a^3i + sum x_i x_j (a^(2i+j) + a^(2j+i))
	function automatic logic [NT-1:0] cube_mask(int pos);
		logic [NT-1:0] m;
		gf_pkg::gf_elem_t e0;
		gf_pkg::gf_elem_t e1;
		m = '0;
		for (int i = 0; i < `GF_M; i++) begin
			e0   = gf_pkg::gf_alpha_pow(3 * i);
			m[i] = e0[pos];
		end
		for (int i = 0; i < `GF_M - 1; i++)
			for (int j = i + 1; j < `GF_M; j++) begin
				e0 = gf_pkg::gf_alpha_pow(2 * i + j);
				e1 = gf_pkg::gf_alpha_pow(2 * j + i);
				m[pair_idx(i, j)] = e0[pos] ^ e1[pos];
			end
		return m;
	endfunction

	logic [NT-1:0] terms;

	genvar i, j;

	generate
		for (i = 0; i < `GF_M; i++) begin : g_single
			assign terms[i] = x[i];
		end
		for (i = 0; i < `GF_M - 1; i++) begin : g_row
			for (j = i + 1; j < `GF_M; j++) begin : g_pair
				assign terms[pair_idx(i, j)] = x[i] & x[j];
			end
		end
		for (i = 0; i < `GF_M; i++) begin : g_out
			assign sq[i]   = ^(x & sq_mask(i));      // Linear in x so no products
			assign cube[i] = ^(terms & cube_mask(i));
		end
	endgenerate

endmodule

//--- hdl/gf_seq_ctrl.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

// Command capture, step sequencing and result strobe
module gf_seq_ctrl (
	input                      clk,
	input                      reset,
	input                      cmd_valid,
	input  gf_pkg::gf_cmd_t    cmd,
	output gf_pkg::gf_step_t   step,
	output gf_pkg::gf_elem_t   a,
	output gf_pkg::gf_elem_t   b,
	input  gf_pkg::gf_elem_t   acc,
	output logic               busy,
	output logic               result_valid,
	output gf_pkg::gf_result_t result
);

	// Counter values after the last step of each iterative op
	localparam gf_pkg::gf_elem_t INV_END = gf_pkg::gf_alpha_pow(`GF_INV_STEPS);
	localparam gf_pkg::gf_elem_t POW_END = gf_pkg::gf_alpha_pow(`GF_POW_STEPS);

	gf_pkg::gf_op_t     op_q;
	gf_pkg::gf_exp_t    exp_q;
	gf_pkg::gf_elem_t   cnt;       // LFSR step counter
	gf_pkg::gf_elem_t   cnt_next;
	gf_pkg::gf_elem_t   cnt_end;
	gf_pkg::gf_result_t result_q;  // Last result, held between strobes
	gf_pkg::gf_mode_t   load_mode;
	logic               running;
	logic               accept;
	logic               iterative;
	logic               last;

	assign accept = cmd_valid && !busy;
	assign busy   = running || result_valid;

	// Operand word decoded as an element here, as an exponent on capture
	assign a = cmd.a;
	assign b = cmd.b.elem;

	assign cnt_next = gf_pkg::gf_mul_alpha(cnt);
	assign cnt_end  = (op_q == gf_pkg::OP_INV) ? INV_END : POW_END;
	assign last     = running && (cnt_next == cnt_end);

	always_comb begin
		case (cmd.op)
			gf_pkg::OP_SQR:  load_mode = gf_pkg::MODE_SQR;
			gf_pkg::OP_CUBE: load_mode = gf_pkg::MODE_CUBE;
			gf_pkg::OP_INV:  load_mode = gf_pkg::MODE_INV_STEP;
			gf_pkg::OP_POW:  load_mode = gf_pkg::MODE_POW_STEP;
			default:         load_mode = gf_pkg::MODE_MUL;
		endcase
	end

	assign iterative = (cmd.op == gf_pkg::OP_INV) || (cmd.op == gf_pkg::OP_POW);

	always_comb begin
		step.load    = accept;
		step.run     = running;
		step.exp_bit = exp_q[`GF_M-1];
		if (accept)
			step.mode = load_mode; // Straight from the command in the accept cycle
		else if (op_q == gf_pkg::OP_INV)
			step.mode = gf_pkg::MODE_INV_STEP;
		else
			step.mode = gf_pkg::MODE_POW_STEP;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q         <= gf_pkg::OP_MUL;
			exp_q        <= '0;
			cnt          <= `GF_ONE;
			running      <= 1'b0;
			result_valid <= 1'b0;
			result_q     <= '0;
		end else begin
			result_valid <= 1'b0;
			if (result_valid)
				result_q <= result; // Keep it once acc moves on
			if (accept) begin
				op_q  <= cmd.op;
				exp_q <= cmd.b.exp;
				cnt   <= `GF_ONE;
				if (iterative)
					running <= 1'b1;
				else
					result_valid <= 1'b1; // Single-cycle ops are done at load
			end else if (running) begin
				cnt   <= cnt_next;
				exp_q <= exp_q << 1;
				if (last) begin
					running      <= 1'b0;
					result_valid <= 1'b1;
				end
			end
		end
	end

	// Live accumulator during the strobe, held copy afterwards
	always_comb begin
		if (result_valid) begin
			result.op    = op_q;
			result.value = acc;
		end else begin
			result = result_q;
		end
	end

endmodule

//--- hdl/gf_accum.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

// Base and accumulator registers around the field arithmetic
module gf_accum (
	input                    clk,
	input                    reset,
	input  gf_pkg::gf_step_t step,
	input  gf_pkg::gf_elem_t a,
	input  gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t acc
);

	gf_pkg::gf_elem_t base;
	gf_pkg::gf_elem_t pm_in;
	gf_pkg::gf_elem_t base_sq;
	gf_pkg::gf_elem_t base_cube;
	gf_pkg::gf_elem_t acc_sq;
	gf_pkg::gf_elem_t m0_a;
	gf_pkg::gf_elem_t m0_b;
	gf_pkg::gf_elem_t m0_p;
	gf_pkg::gf_elem_t m1_p;

	// At load the operand itself goes through the maps, later the base
	assign pm_in = step.load ? a : base;

	gf_power_map u_pm_base (
		.x    (pm_in),
		.sq   (base_sq),
		.cube (base_cube)
	);

	gf_power_map u_pm_acc (
		.x    (acc),
		.sq   (acc_sq),
		.cube ()
	);

	// a*b for MUL, acc * base^2 for an inversion step
	assign m0_a = step.load ? a : acc;
	assign m0_b = step.load ? b : base_sq;

	gf_mult u_mult0 (
		.a (m0_a),
		.b (m0_b),
		.p (m0_p)
	);

	// acc^2 * base for a POW step with the exponent bit set
	gf_mult u_mult1 (
		.a (acc_sq),
		.b (base),
		.p (m1_p)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			base <= '0;
			acc  <= '0;
		end else if (step.load) begin
			base <= a;
			case (step.mode)
				gf_pkg::MODE_MUL:  acc <= m0_p;
				gf_pkg::MODE_SQR:  acc <= base_sq;
				gf_pkg::MODE_CUBE: acc <= base_cube;
				default:           acc <= `GF_ONE; // INV and POW start from one
			endcase
		end else if (step.run) begin
			case (step.mode)
				gf_pkg::MODE_INV_STEP: begin
					base <= base_sq;
					acc  <= m0_p;
				end
				gf_pkg::MODE_POW_STEP: acc <= step.exp_bit ? m1_p : acc_sq;
				default: ;
			endcase
		end
	end

endmodule

//--- hdl/gf_alu_top.sv
`timescale 1ns/100ps

// GF(2^8) arithmetic unit, one command in flight
module gf_alu_top (
	input                      clk,
	input                      reset,
	input                      cmd_valid,
	input  gf_pkg::gf_cmd_t    cmd,
	output logic               busy,
	output logic               result_valid,
	output gf_pkg::gf_result_t result
);

	gf_pkg::gf_step_t step;
	gf_pkg::gf_elem_t a;
	gf_pkg::gf_elem_t b;
	gf_pkg::gf_elem_t acc;

	gf_seq_ctrl u_seq_ctrl (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.step         (step),
		.a            (a),
		.b            (b),
		.acc          (acc),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	gf_accum u_accum (
		.clk   (clk),
		.reset (reset),
		.step  (step),
		.a     (a),
		.b     (b),
		.acc   (acc)
	);

endmodule

//--- test/gf_alu_asserts.sv
`timescale 1ns/100ps

// Handshake properties of the sequencer
module gf_alu_asserts (
	input logic clk,
	input logic reset,
	input logic accept,
	input logic busy,
	input logic result_valid
);

	// Result strobe lasts a single cycle
	a_strobe_width: assert property (@(posedge clk) disable iff (reset)
		result_valid |=> !result_valid)
		else $error("result_valid stayed high for a second cycle");

	a_idle_after: assert property (@(posedge clk) disable iff (reset)
		result_valid |=> !busy)
		else $error("busy still high in the cycle after result_valid");

	// An accepted command holds off the next one from the following cycle
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		accept |=> busy)
		else $error("busy not raised in the cycle after a command was accepted");

endmodule

//--- test/gf_alu_checker.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

// Scoreboard on the top-level ports, sampled at the falling edge
module gf_alu_checker (
	input                     clk,
	input                     reset,
	input                     cmd_valid,
	input gf_pkg::gf_cmd_t    cmd,
	input                     busy,
	input                     result_valid,
	input gf_pkg::gf_result_t result
);

	int    tests = 0;
	int    checks = 0;
	int    errors = 0;
	int    test_checks = 0;
	int    test_errors = 0;
	string test_name = "none";

	int               cycle = 0;
	int               pend_cycle = 0;
	logic             in_reset = 1'b1;
	logic             pending = 1'b0;  // Accepted command awaiting its result
	logic             held = 1'b0;
	gf_pkg::gf_cmd_t  pend_cmd;
	gf_pkg::gf_elem_t last_value;

	// Shift-and-add product, reduced on every shift of the partial term
	function automatic gf_pkg::gf_elem_t gf_ref_mul(gf_pkg::gf_elem_t x, gf_pkg::gf_elem_t y);
		gf_pkg::gf_elem_t p;
		gf_pkg::gf_elem_t s;
		p = '0;
		s = x;
		for (int i = 0; i < `GF_M; i++) begin
			if (y[i])
				p = p ^ s;
			if (s[`GF_M-1])
				s = (s << 1) ^ gf_pkg::gf_elem_t'(`GF_POLY);
			else
				s = s << 1;
		end
		return p;
	endfunction

	function automatic gf_pkg::gf_elem_t gf_ref_pow(gf_pkg::gf_elem_t x, int k);
		gf_pkg::gf_elem_t r;
		r = `GF_ONE; // x^0 is one, zero included
		for (int i = 0; i < k; i++)
			r = gf_ref_mul(r, x);
		return r;
	endfunction

	function automatic gf_pkg::gf_elem_t expected_value(gf_pkg::gf_cmd_t c);
		gf_pkg::gf_elem_t v;
		case (c.op)
			gf_pkg::OP_MUL:  v = gf_ref_mul(c.a, c.b.elem);
			gf_pkg::OP_SQR:  v = gf_ref_pow(c.a, 2);
			gf_pkg::OP_CUBE: v = gf_ref_pow(c.a, 3);
			gf_pkg::OP_INV:  v = gf_ref_pow(c.a, (1 << `GF_M) - 2);
			default:         v = gf_ref_pow(c.a, int'(c.b.exp));
		endcase
		return v;
	endfunction

	// Accepting edge to result edge
	function automatic int expected_latency(gf_pkg::gf_op_t op);
		if (op == gf_pkg::OP_INV)
			return `GF_M;
		else if (op == gf_pkg::OP_POW)
			return `GF_M + 1;
		return 1;
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests++;
		$display("Test %s finished: %0d checks, %0d errors", test_name, test_checks, test_errors);
	endtask

	task automatic report_counts();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
	endtask

	task automatic compare(input string what, input int expected, input int actual);
		checks++;
		test_checks++;
		if (expected != actual) begin
			errors++;
			test_errors++;
			$display("Mismatch in %s (%s): expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic fail(input string msg);
		errors++;
		test_errors++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	task automatic check_result();
		gf_pkg::gf_elem_t exp_v;
		if (!pending) begin
			fail("result_valid rose with no command in flight");
		end else begin
			exp_v = expected_value(pend_cmd);
			compare("value", int'(exp_v), int'(result.value));
			compare("op", int'(pend_cmd.op), int'(result.op));
			compare("latency", expected_latency(pend_cmd.op), cycle - pend_cycle);
			if (pend_cmd.op == gf_pkg::OP_INV && pend_cmd.a != '0)
				compare("a times inverse", `GF_ONE, int'(gf_ref_mul(pend_cmd.a, result.value)));
			pending = 1'b0;
		end
		last_value = result.value;
		held = 1'b1;
	endtask

	always @(negedge clk) begin
		cycle++;
		if (reset) begin
			in_reset = 1'b1;
			pending = 1'b0;
			held = 1'b0;
		end else begin
			if (in_reset) begin
				// First cycle out of reset
				compare("busy after reset", 0, int'(busy));
				compare("result_valid after reset", 0, int'(result_valid));
				compare("result after reset", 0, int'(result));
				in_reset = 1'b0;
			end
			if (result_valid)
				check_result();
			else if (held && result.value != last_value)
				fail("result changed while result_valid was low");
			if (cmd_valid && !busy) begin
				pending = 1'b1;
				pend_cmd = cmd;
				pend_cycle = cycle;
			end
		end
	end

endmodule

//--- test/gf_alu_tb.sv
`timescale 1ns/100ps

`include "gf_settings.svh"

module gf_alu_tb;

	localparam int DRIVE_DELAY = 2;
	localparam int RESULT_TIMEOUT = 20;

	logic               clk;
	logic               reset;
	logic               cmd_valid;
	gf_pkg::gf_cmd_t    cmd;
	logic               busy;
	logic               result_valid;
	gf_pkg::gf_result_t result;
	logic               timed_out;
	logic               setup_error;

	gf_alu_top gf_alu_top_i (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	gf_alu_checker checker_i (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	bind gf_seq_ctrl gf_alu_asserts gf_alu_asserts_i (
		.clk          (clk),
		.reset        (reset),
		.accept       (accept),
		.busy         (busy),
		.result_valid (result_valid)
	);

	always #10 clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// One-cycle command strobe, returns just after the accepting edge
	task automatic drive_cmd(input gf_pkg::gf_op_t op, input gf_pkg::gf_elem_t x,
			input gf_pkg::gf_elem_t w);
		next_cycle();
		cmd_valid = 1'b1;
		cmd.op = op;
		cmd.a = x;
		if (op == gf_pkg::OP_POW)
			cmd.b.exp = w; // Same word read as an exponent
		else
			cmd.b.elem = w;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic wait_result();
		int n;
		n = 0;
		while (!result_valid && n < RESULT_TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!result_valid) begin
			timed_out = 1'b1;
			$display("Timeout: no result_valid within %0d cycles of the command", RESULT_TIMEOUT);
		end
	endtask

	task automatic run_cmd(input gf_pkg::gf_op_t op, input gf_pkg::gf_elem_t x,
			input gf_pkg::gf_elem_t w);
		if (!timed_out) begin
			drive_cmd(op, x, w);
			wait_result();
		end
	endtask

	// Strobe in the current cycle, which must find the unit busy
	task automatic strobe_busy(input gf_pkg::gf_op_t op, input gf_pkg::gf_elem_t x,
			input gf_pkg::gf_elem_t w);
		if (!busy) begin
			setup_error = 1'b1;
			$display("Command meant to be ignored found the unit idle");
		end
		cmd_valid = 1'b1;
		cmd.op = op;
		cmd.a = x;
		cmd.b.elem = w;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		gf_pkg::gf_elem_t w;
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		timed_out = 1'b0;
		setup_error = 1'b0;
		r = $urandom(32'h5d109814);

		checker_i.begin_test("reset_state");
		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		next_cycle();
		checker_i.end_test();

		checker_i.begin_test("mul_random");
		for (int i = 0; i < 200; i++) begin
			r = $urandom;
			run_cmd(gf_pkg::OP_MUL, r[7:0], r[15:8]);
		end
		checker_i.end_test();

		checker_i.begin_test("sqr_cube_all");
		for (int i = 0; i < (1 << `GF_M); i++) begin
			run_cmd(gf_pkg::OP_SQR, gf_pkg::gf_elem_t'(i), 8'h00);
			run_cmd(gf_pkg::OP_CUBE, gf_pkg::gf_elem_t'(i), 8'h00);
		end
		checker_i.end_test();

		checker_i.begin_test("inv_all");
		for (int i = 0; i < (1 << `GF_M); i++)
			run_cmd(gf_pkg::OP_INV, gf_pkg::gf_elem_t'(i), 8'h00);
		checker_i.end_test();

		// Each b word goes to POW as an exponent, then to MUL as an element
		checker_i.begin_test("pow_and_union");
		for (int i = 0; i < 60; i++) begin
			r = $urandom;
			case (i % 4)
				0:       w = 8'h00;
				1:       w = 8'h01;
				2:       w = 8'hff;
				default: w = r[15:8];
			endcase
			run_cmd(gf_pkg::OP_POW, r[7:0], w);
			run_cmd(gf_pkg::OP_MUL, r[7:0], w);
		end
		checker_i.end_test();

		checker_i.begin_test("latency_busy");
		run_cmd(gf_pkg::OP_MUL, 8'h57, 8'h83);
		run_cmd(gf_pkg::OP_SQR, 8'h57, 8'h00);
		run_cmd(gf_pkg::OP_CUBE, 8'h57, 8'h00);
		run_cmd(gf_pkg::OP_INV, 8'h57, 8'h00);
		run_cmd(gf_pkg::OP_POW, 8'h57, 8'hc5);
		drive_cmd(gf_pkg::OP_INV, 8'h9a, 8'h00);
		idle(3);
		strobe_busy(gf_pkg::OP_MUL, 8'h12, 8'h34); // Mid-inversion
		wait_result();
		strobe_busy(gf_pkg::OP_SQR, 8'h77, 8'h00); // Lands on the result cycle
		drive_cmd(gf_pkg::OP_POW, 8'h3c, 8'hfe);
		idle(7);
		strobe_busy(gf_pkg::OP_CUBE, 8'h21, 8'h00);
		wait_result();
		idle(12); // A stray result would show up here
		checker_i.end_test();

		checker_i.report_counts();
		if (timed_out || setup_error || checker_i.errors != 0)
			$display("TESTS FAILED");
		else
			$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
hdl/gf_pkg.sv
hdl/gf_mult.sv
hdl/gf_power_map.sv
hdl/gf_seq_ctrl.sv
hdl/gf_accum.sv
hdl/gf_alu_top.sv
test/gf_alu_asserts.sv
test/gf_alu_checker.sv
test/gf_alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GF(2^8) unit testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module gf_alu_tb -o gf_alu_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/gf_alu_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "TESTS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
